//--- arm_core_pkg.sv
// shared types for the data-processing-only core; r15 is a plain register, condition 0xF means never
package arm_core_pkg;

    parameter int NUM_REGS = 16;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [3:0]  nzcv_t;     // {n, z, c, v}
    typedef logic [3:0]  alu_op_t;   // ins[24:21]
    typedef logic [3:0]  cond_t;     // ins[31:28]
    typedef logic [31:0] ins_t;

    localparam alu_op_t OP_AND = 4'd0;
    localparam alu_op_t OP_EOR = 4'd1;
    localparam alu_op_t OP_SUB = 4'd2;
    localparam alu_op_t OP_ADD = 4'd4;
    localparam alu_op_t OP_TST = 4'd8;
    localparam alu_op_t OP_CMP = 4'd10;
    localparam alu_op_t OP_ORR = 4'd12;
    localparam alu_op_t OP_MOV = 4'd13;
    localparam alu_op_t OP_MVN = 4'd15;

    localparam cond_t COND_EQ = 4'd0;
    localparam cond_t COND_NE = 4'd1;
    localparam cond_t COND_CS = 4'd2;
    localparam cond_t COND_CC = 4'd3;
    localparam cond_t COND_MI = 4'd4;
    localparam cond_t COND_PL = 4'd5;
    localparam cond_t COND_VS = 4'd6;
    localparam cond_t COND_VC = 4'd7;
    localparam cond_t COND_HI = 4'd8;
    localparam cond_t COND_LS = 4'd9;
    localparam cond_t COND_GE = 4'd10;
    localparam cond_t COND_LT = 4'd11;
    localparam cond_t COND_GT = 4'd12;
    localparam cond_t COND_LE = 4'd13;
    localparam cond_t COND_AL = 4'd14;
    localparam cond_t COND_NV = 4'd15;    // never

    // issue to execute
    typedef struct packed {
        cond_t       cond;
        alu_op_t     op;
        logic        s;
        logic        imm;
        logic [11:0] operand12;
        reg_addr_t   rd;
        logic        wr_en;
        word_t       rn_val;
        word_t       rm_val;
        logic        valid;
    } issue_rec_t;

    // execute to writeback and out of the core
    typedef struct packed {
        reg_addr_t rd;
        word_t     result;
        logic      wb_en;
        logic      executed;
        nzcv_t     nzcv;      // flags after the instruction
        logic      valid;
    } retire_rec_t;

endpackage

//--- ins_queue.sv
// sender must hold a credit per push; pushing into a full queue is illegal and not recovered
`timescale 1ns/1ps

module ins_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               i_reset_n,
    input  logic               i_push,
    input  arm_core_pkg::ins_t i_ins,
    input  logic               i_pop,
    output arm_core_pkg::ins_t o_head,
    output logic               o_head_valid,
    output logic               o_credit
);
    import arm_core_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    ins_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_head       = mem[rd_ptr];
    assign o_head_valid = (count != '0);
    assign do_pop       = i_pop && o_head_valid;
    assign o_credit     = do_pop;    // one credit per entry handed to issue

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_ins;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(i_push) - CNT_W'(do_pop);
        end
    end

    // credits returned to the sender must keep it off a full queue
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!i_reset_n)
        i_push |-> (count < CNT_W'(QUEUE_DEPTH)));

endmodule

//--- register_bank.sv
// two async read ports, one write port; no write-to-read bypass, a new value shows the next cycle
`timescale 1ns/1ps

module register_bank (
    input  logic                    clk,
    input  logic                    i_reset_n,
    input  arm_core_pkg::reg_addr_t i_rd_addr_a,
    input  arm_core_pkg::reg_addr_t i_rd_addr_b,
    input  logic                    i_wr_en,
    input  arm_core_pkg::reg_addr_t i_wr_addr,
    input  arm_core_pkg::word_t     i_wr_data,
    output arm_core_pkg::word_t     o_rd_data_a,
    output arm_core_pkg::word_t     o_rd_data_b
);
    import arm_core_pkg::*;

    word_t regs [NUM_REGS];    // r15 has no pc role here

    assign o_rd_data_a = regs[i_rd_addr_a];
    assign o_rd_data_b = regs[i_rd_addr_b];

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;    // core starts from all-zero state
            end
        end else if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

//--- issue_stage.sv
// data-processing decode only; other forms issue as condition never and retire unexecuted
`timescale 1ns/1ps

module issue_stage (
    input  logic                      clk,
    input  logic                      i_reset_n,
    input  arm_core_pkg::ins_t        i_head,
    input  logic                      i_head_valid,
    output logic                      o_pop,
    output arm_core_pkg::reg_addr_t   o_rd_addr_a,
    output arm_core_pkg::reg_addr_t   o_rd_addr_b,
    input  arm_core_pkg::word_t       i_rd_data_a,
    input  arm_core_pkg::word_t       i_rd_data_b,
    input  arm_core_pkg::issue_rec_t  i_exec_rec,
    input  arm_core_pkg::retire_rec_t i_wb_rec,
    output arm_core_pkg::issue_rec_t  o_issue
);
    import arm_core_pkg::*;

    alu_op_t    op;
    logic       dp_type;
    logic       kept_op;
    logic       writes_rd;
    logic       uses_rn;
    logic       uses_rm;
    logic       hazard;
    issue_rec_t issue_next;

    // a pending write to addr anywhere between here and the bank
    function automatic logic in_flight(input reg_addr_t addr, input issue_rec_t iss,
                                       input issue_rec_t exe, input retire_rec_t wb);
        return (iss.valid && iss.wr_en && iss.rd == addr)
            || (exe.valid && exe.wr_en && exe.rd == addr)
            || (wb.valid && wb.wb_en && wb.rd == addr);
    endfunction

    assign op          = i_head[24:21];
    assign dp_type     = (i_head[27:26] == 2'b00);
    assign o_rd_addr_a = i_head[19:16];    // rn
    assign o_rd_addr_b = i_head[3:0];      // rm
    assign uses_rn     = (op != OP_MOV) && (op != OP_MVN);
    assign uses_rm     = !i_head[25];      // immediate form has no rm

    always_comb begin
        kept_op   = 1'b1;
        writes_rd = 1'b0;
        case (op)
            OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_ORR, OP_MOV, OP_MVN: writes_rd = 1'b1;
            OP_TST, OP_CMP:                                         writes_rd = 1'b0;
            default:                                                kept_op   = 1'b0;
        endcase
    end

    always_comb begin
        hazard = (uses_rn && in_flight(o_rd_addr_a, o_issue, i_exec_rec, i_wb_rec))
              || (uses_rm && in_flight(o_rd_addr_b, o_issue, i_exec_rec, i_wb_rec));
    end

    assign o_pop = i_head_valid && !hazard;

    always_comb begin
        issue_next.cond      = (dp_type && kept_op) ? i_head[31:28] : COND_NV;
        issue_next.op        = op;
        issue_next.s         = i_head[20];
        issue_next.imm       = i_head[25];
        issue_next.operand12 = i_head[11:0];
        issue_next.rd        = i_head[15:12];
        issue_next.wr_en     = dp_type && writes_rd;
        issue_next.rn_val    = i_rd_data_a;
        issue_next.rm_val    = i_rd_data_b;
        issue_next.valid     = o_pop;    // bubble while stalled
    end

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            o_issue.valid <= 1'b0;
        end else begin
            o_issue <= issue_next;
        end
    end

endmodule

//--- operand_shifter.sv
// shift amount 0 passes rm unchanged for all types; no rrx and no 32-bit shift forms
`timescale 1ns/1ps

module operand_shifter (
    input  logic                i_imm,
    input  logic [11:0]         i_operand12,
    input  arm_core_pkg::word_t i_rm_value,
    output arm_core_pkg::word_t o_operand2
);
    import arm_core_pkg::*;

    localparam logic [1:0] SH_LSL = 2'b00;
    localparam logic [1:0] SH_LSR = 2'b01;
    localparam logic [1:0] SH_ASR = 2'b10;
    localparam logic [1:0] SH_ROR = 2'b11;

    logic [4:0] rot_amt;
    logic [4:0] sh_amt;
    word_t      imm32;
    word_t      shifted;

    // left part vanishes for amt 0 since a shift by 32 clears the word
    function automatic word_t ror32(input word_t value, input logic [4:0] amt);
        return (value >> amt) | (value << (6'd32 - {1'b0, amt}));
    endfunction

    assign rot_amt = {i_operand12[11:8], 1'b0};    // rotate by twice the field
    assign sh_amt  = i_operand12[11:7];
    assign imm32   = ror32({24'b0, i_operand12[7:0]}, rot_amt);

    always_comb begin
        case (i_operand12[6:5])
            SH_LSL:  shifted = i_rm_value << sh_amt;
            SH_LSR:  shifted = i_rm_value >> sh_amt;
            SH_ASR:  shifted = word_t'($signed(i_rm_value) >>> sh_amt);
            SH_ROR:  shifted = ror32(i_rm_value, sh_amt);
            default: shifted = i_rm_value;
        endcase
    end

    assign o_operand2 = i_imm ? imm32 : shifted;

endmodule

//--- exec_stage.sv
// no carry-in ops and no shifter carry-out; logical ops keep c and v from the flag register
`timescale 1ns/1ps

module exec_stage (
    input  logic                      clk,
    input  logic                      i_reset_n,
    input  arm_core_pkg::issue_rec_t  i_issue,
    output arm_core_pkg::issue_rec_t  o_exec_rec,
    output arm_core_pkg::retire_rec_t o_retire
);
    import arm_core_pkg::*;

    nzcv_t       flags;
    nzcv_t       flags_next;
    nzcv_t       alu_flags;
    logic        fn;
    logic        fz;
    logic        fc;
    logic        fv;
    word_t       operand2;
    word_t       result;
    logic        carry;
    logic        overflow;
    logic        is_sub;
    logic        is_arith;
    logic        cond_pass;
    logic        executed;
    logic        set_flags;
    retire_rec_t retire_next;

    operand_shifter operand_shifter_inst (
        .i_imm       (i_issue.imm),
        .i_operand12 (i_issue.operand12),
        .i_rm_value  (i_issue.rm_val),
        .o_operand2  (operand2)
    );

    assign {fn, fz, fc, fv} = flags;

    always_comb begin
        case (i_issue.cond)
            COND_EQ: cond_pass = fz;
            COND_NE: cond_pass = !fz;
            COND_CS: cond_pass = fc;
            COND_CC: cond_pass = !fc;
            COND_MI: cond_pass = fn;
            COND_PL: cond_pass = !fn;
            COND_VS: cond_pass = fv;
            COND_VC: cond_pass = !fv;
            COND_HI: cond_pass = fc && !fz;
            COND_LS: cond_pass = !fc || fz;
            COND_GE: cond_pass = (fn == fv);
            COND_LT: cond_pass = (fn != fv);
            COND_GT: cond_pass = !fz && (fn == fv);
            COND_LE: cond_pass = fz || (fn != fv);
            COND_AL: cond_pass = 1'b1;
            default: cond_pass = 1'b0;    // 0xf never
        endcase
    end

    always_comb begin
        carry = 1'b0;
        case (i_issue.op)
            OP_AND, OP_TST: result = i_issue.rn_val & operand2;
            OP_EOR:         result = i_issue.rn_val ^ operand2;
            OP_ORR:         result = i_issue.rn_val | operand2;
            OP_MOV:         result = operand2;
            OP_MVN:         result = ~operand2;
            OP_ADD:         {carry, result} = {1'b0, i_issue.rn_val} + {1'b0, operand2};
            OP_SUB, OP_CMP: {carry, result} = {1'b0, i_issue.rn_val} + {1'b0, ~operand2} + 33'd1;
            default:        result = '0;
        endcase
    end

    assign is_sub   = (i_issue.op == OP_SUB) || (i_issue.op == OP_CMP);
    assign is_arith = is_sub || (i_issue.op == OP_ADD);
    // carry on subtract reads as no borrow
    assign overflow = is_sub
        ? (i_issue.rn_val[31] != operand2[31]) && (result[31] != i_issue.rn_val[31])
        : (i_issue.rn_val[31] == operand2[31]) && (result[31] != i_issue.rn_val[31]);
    assign alu_flags = is_arith ? {result[31], result == '0, carry, overflow}
                                : {result[31], result == '0, fc, fv};

    assign executed   = i_issue.valid && cond_pass;
    assign set_flags  = executed && (i_issue.s || i_issue.op == OP_TST || i_issue.op == OP_CMP);
    assign flags_next = set_flags ? alu_flags : flags;

    always_comb begin
        retire_next.rd       = i_issue.rd;
        retire_next.result   = result;
        retire_next.wb_en    = executed && i_issue.wr_en;
        retire_next.executed = executed;
        retire_next.nzcv     = flags_next;
        retire_next.valid    = i_issue.valid;
    end

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            flags            <= '0;
            o_retire.valid   <= 1'b0;
            o_exec_rec.valid <= 1'b0;
        end else begin
            flags      <= flags_next;    // next instruction sees these
            o_retire   <= retire_next;
            o_exec_rec <= i_issue;       // kept for issue hazard checks
        end
    end

    a_wb_only_when_executed: assert property (@(posedge clk) disable iff (!i_reset_n)
        o_retire.valid && o_retire.wb_en |-> o_retire.executed);

endmodule

//--- writeback_stage.sv
// bank write and retire report come from the same register; the retire port has no back-pressure
`timescale 1ns/1ps

module writeback_stage (
    input  logic                      clk,
    input  logic                      i_reset_n,
    input  arm_core_pkg::retire_rec_t i_retire,
    output logic                      o_wr_en,
    output arm_core_pkg::reg_addr_t   o_wr_addr,
    output arm_core_pkg::word_t       o_wr_data,
    output logic                      o_retire_valid,
    output arm_core_pkg::retire_rec_t o_retire
);
    import arm_core_pkg::*;

    retire_rec_t wb_q;

    always_ff @(posedge clk) begin
        if (!i_reset_n) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q <= i_retire;
        end
    end

    assign o_wr_en        = wb_q.valid && wb_q.wb_en;    // lands at the next edge
    assign o_wr_addr      = wb_q.rd;
    assign o_wr_data      = wb_q.result;
    assign o_retire_valid = wb_q.valid;
    assign o_retire       = wb_q;

endmodule

//--- arm_core.sv
// data-processing only; a retire follows its credit pulse by exactly 3 cycles
`timescale 1ns/1ps

module arm_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      i_reset_n,
    input  logic                      i_ins_valid,
    input  arm_core_pkg::ins_t        i_ins,
    output logic                      o_credit,
    output logic                      o_retire_valid,
    output arm_core_pkg::retire_rec_t o_retire
);
    import arm_core_pkg::*;

    ins_t        head;
    logic        head_valid;
    logic        pop;
    reg_addr_t   rd_addr_a;
    reg_addr_t   rd_addr_b;
    word_t       rd_data_a;
    word_t       rd_data_b;
    logic        wr_en;
    reg_addr_t   wr_addr;
    word_t       wr_data;
    issue_rec_t  issue_rec;
    issue_rec_t  exec_rec;
    retire_rec_t exec_retire;

    ins_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) ins_queue_inst (
        .clk          (clk),
        .i_reset_n    (i_reset_n),
        .i_push       (i_ins_valid),
        .i_ins        (i_ins),
        .i_pop        (pop),
        .o_head       (head),
        .o_head_valid (head_valid),
        .o_credit     (o_credit)
    );

    register_bank register_bank_inst (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    issue_stage issue_stage_inst (
        .clk          (clk),
        .i_reset_n    (i_reset_n),
        .i_head       (head),
        .i_head_valid (head_valid),
        .o_pop        (pop),
        .o_rd_addr_a  (rd_addr_a),
        .o_rd_addr_b  (rd_addr_b),
        .i_rd_data_a  (rd_data_a),
        .i_rd_data_b  (rd_data_b),
        .i_exec_rec   (exec_rec),
        .i_wb_rec     (o_retire),    // writeback register feeds hazard check
        .o_issue      (issue_rec)
    );

    exec_stage exec_stage_inst (
        .clk        (clk),
        .i_reset_n  (i_reset_n),
        .i_issue    (issue_rec),
        .o_exec_rec (exec_rec),
        .o_retire   (exec_retire)
    );

    writeback_stage writeback_stage_inst (
        .clk            (clk),
        .i_reset_n      (i_reset_n),
        .i_retire       (exec_retire),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

endmodule

//--- tb_arm_core.sv
// in-order ISA model, so retires must come in send order; sender credits start at QUEUE_DEPTH
`timescale 1ns/1ps

module tb_arm_core;
    import arm_core_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_RANDOM  = 400;
    localparam int WAIT_LIMIT  = 200;

    logic        clk;
    logic        i_reset_n;
    logic        i_ins_valid;
    ins_t        i_ins;
    logic        o_credit;
    logic        o_retire_valid;
    retire_rec_t o_retire;

    integer seed;
    int     sent;
    int     returned;
    int     retired;
    int     cycle_cnt;
    ins_t   sent_q [$];          // program order, front retires next
    int     credit_cycle_q [$];  // cycle of each pop
    word_t  model_regs [NUM_REGS];
    nzcv_t  model_nzcv;

    arm_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) arm_core_inst (
        .clk            (clk),
        .i_reset_n      (i_reset_n),
        .i_ins_valid    (i_ins_valid),
        .i_ins          (i_ins),
        .o_credit       (o_credit),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (got !== expected) begin
            stop_run($sformatf("MISMATCH %s expected %h got %h", name, expected, got));
        end
    endtask

    function automatic ins_t encode_dp(input cond_t cond, input logic imm, input alu_op_t op,
                                       input logic s, input reg_addr_t rn, input reg_addr_t rd,
                                       input logic [11:0] op12);
        return {cond, 2'b00, imm, op, s, rn, rd, op12};
    endfunction

    // operands and destinations stay in r0..r3 so hazards are frequent
    function automatic ins_t random_ins();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [11:0] op12;
        alu_op_t     op;
        int          idx;
        r1  = $random(seed);
        r2  = $random(seed);
        idx = int'(r1[7:0]) % 9;
        case (idx)
            0:       op = OP_AND;
            1:       op = OP_EOR;
            2:       op = OP_SUB;
            3:       op = OP_ADD;
            4:       op = OP_TST;
            5:       op = OP_CMP;
            6:       op = OP_ORR;
            7:       op = OP_MOV;
            default: op = OP_MVN;
        endcase
        if (r1[8]) begin
            op12 = r2[11:0];
        end else begin
            op12 = {r2[11:5], 3'b000, r2[13:12]};    // amount, type, rm
        end
        return encode_dp(r1[15:12], r1[8], op, r1[9], {2'b00, r1[17:16]},
                         {2'b00, r1[19:18]}, op12);
    endfunction

    function automatic word_t ref_operand2(input ins_t ins, input word_t rm_v);
        logic [63:0] dbl;
        logic [4:0]  amt;
        word_t       op2;
        if (ins[25]) begin
            amt = {ins[11:8], 1'b0};
            dbl = {24'd0, ins[7:0], 24'd0, ins[7:0]} >> amt;
            op2 = dbl[31:0];
        end else begin
            amt = ins[11:7];
            case (ins[6:5])
                2'b00:   op2 = rm_v << amt;
                2'b01:   op2 = rm_v >> amt;
                2'b10: begin
                    dbl = {{32{rm_v[31]}}, rm_v} >> amt;    // sign fill from the top
                    op2 = dbl[31:0];
                end
                default: begin
                    dbl = {rm_v, rm_v} >> amt;
                    op2 = dbl[31:0];
                end
            endcase
        end
        return op2;
    endfunction

    // odd codes are the inverse of the even code below them
    function automatic logic cond_holds(input cond_t cond, input nzcv_t f);
        logic n;
        logic z;
        logic c;
        logic v;
        logic base;
        {n, z, c, v} = f;
        case (cond[3:1])
            3'd0:    base = z;
            3'd1:    base = c;
            3'd2:    base = n;
            3'd3:    base = v;
            3'd4:    base = c && !z;
            3'd5:    base = (n == v);
            3'd6:    base = !z && (n == v);
            default: base = 1'b1;
        endcase
        if (cond == COND_NV) begin
            return 1'b0;
        end
        return cond[0] ? !base : base;
    endfunction

    task automatic check_retire();
        ins_t        ins;
        alu_op_t     op;
        word_t       rn_v;
        word_t       rm_v;
        word_t       op2;
        word_t       res;
        logic [32:0] sum;
        logic [32:0] wide;
        logic        c_out;
        logic        v_out;
        logic        pass;
        logic        writes;
        int          credit_at;
        if (sent_q.size() == 0 || credit_cycle_q.size() == 0) begin
            stop_run("retire seen without a matching sent instruction and credit");
        end else begin
            ins       = sent_q.pop_front();
            credit_at = credit_cycle_q.pop_front();
            check_value("retire latency", 3, cycle_cnt - credit_at);
            op    = ins[24:21];
            rn_v  = model_regs[ins[19:16]];
            rm_v  = model_regs[ins[3:0]];
            op2   = ref_operand2(ins, rm_v);
            c_out = model_nzcv[1];    // logical ops keep c and v
            v_out = model_nzcv[0];
            case (op)
                OP_ADD: begin
                    sum   = {1'b0, rn_v} + {1'b0, op2};
                    wide  = {rn_v[31], rn_v} + {op2[31], op2};
                    res   = sum[31:0];
                    c_out = sum[32];
                    v_out = (wide[32] != wide[31]);    // signed sum needs 33 bits
                end
                OP_SUB, OP_CMP: begin
                    wide  = {rn_v[31], rn_v} - {op2[31], op2};
                    res   = rn_v - op2;
                    c_out = (rn_v >= op2);    // no borrow
                    v_out = (wide[32] != wide[31]);
                end
                OP_AND, OP_TST: res = rn_v & op2;
                OP_EOR:         res = rn_v ^ op2;
                OP_ORR:         res = rn_v | op2;
                OP_MOV:         res = op2;
                default:        res = ~op2;
            endcase
            pass   = cond_holds(ins[31:28], model_nzcv);
            writes = (op != OP_TST) && (op != OP_CMP);
            if (pass && (ins[20] || !writes)) begin
                model_nzcv = {res[31], res == 32'd0, c_out, v_out};
            end
            if (pass && writes) begin
                model_regs[ins[15:12]] = res;
            end
            check_value("o_retire.valid", 1, 32'(o_retire.valid));
            check_value("o_retire.rd", 32'(ins[15:12]), 32'(o_retire.rd));
            check_value("o_retire.result", res, o_retire.result);
            check_value("o_retire.wb_en", 32'(pass && writes), 32'(o_retire.wb_en));
            check_value("o_retire.executed", 32'(pass), 32'(o_retire.executed));
            check_value("o_retire.nzcv", 32'(model_nzcv), 32'(o_retire.nzcv));
            retired++;
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (i_reset_n) begin
            if (sent == 0) begin
                check_value("o_retire_valid", 0, 32'(o_retire_valid));
                check_value("o_credit", 0, 32'(o_credit));
            end
            if (o_credit) begin
                returned++;
                credit_cycle_q.push_back(cycle_cnt);
                if (returned > sent) begin
                    stop_run("credit returned beyond the number of instructions sent");
                end
            end
            if (o_retire_valid) begin
                check_retire();
            end
        end
    end

    task automatic send_ins(input ins_t ins, input logic gaps);
        int          waited;
        logic [31:0] r;
        logic        go;
        waited = 0;
        go     = 1'b0;
        while (!go) begin
            @(posedge clk);
            r  = $random(seed);
            go = (sent - returned < QUEUE_DEPTH) && (!gaps || r[0]);    // need a credit
            i_ins_valid <= go;
            i_ins       <= ins;
            if (go) begin
                sent_q.push_back(ins);
                sent++;
            end
            waited++;
            if (!go && waited > WAIT_LIMIT) begin
                stop_run("timeout waiting for a credit to send an instruction");
            end
        end
    endtask

    initial begin
        int waited;
        clk         = 1'b0;
        i_reset_n   = 1'b0;
        i_ins_valid = 1'b0;
        i_ins       = '0;
        seed        = 32'hd6cb_dcc9;
        sent        = 0;
        returned    = 0;
        retired     = 0;
        cycle_cnt   = 0;
        model_nzcv  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        i_reset_n <= 1'b1;
        repeat (4) @(posedge clk);    // idle, outputs must stay low
        for (int r = 0; r < 4; r++) begin
            send_ins(encode_dp(COND_AL, 1'b0, OP_MOV, 1'b0, 4'd0, 4'(r), {8'd0, 4'(r)}), 1'b0);
        end
        send_ins(encode_dp(COND_AL, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd1, 12'h102), 1'b0);  // 0x80000000
        send_ins(encode_dp(COND_AL, 1'b1, OP_MVN, 1'b0, 4'd0, 4'd2, 12'h000), 1'b0);  // all ones
        send_ins(encode_dp(COND_AL, 1'b0, OP_ADD, 1'b1, 4'd2, 4'd3, 12'h002), 1'b0);  // carry out
        send_ins(encode_dp(COND_AL, 1'b1, OP_SUB, 1'b1, 4'd1, 4'd0, 12'h001), 1'b0);  // overflow
        send_ins(encode_dp(COND_AL, 1'b0, OP_ADD, 1'b1, 4'd1, 4'd0, 12'h001), 1'b0);  // zero, c, v
        send_ins(encode_dp(COND_VS, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd3, 12'h0ff), 1'b0);
        send_ins(encode_dp(COND_CC, 1'b1, OP_MOV, 1'b0, 4'd0, 4'd3, 12'h011), 1'b0);  // skipped
        send_ins(encode_dp(COND_AL, 1'b0, OP_CMP, 1'b0, 4'd2, 4'd0, 12'h002), 1'b0);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            send_ins(random_ins(), 1'b1);
        end
        @(posedge clk);
        i_ins_valid <= 1'b0;
        waited = 0;
        while (retired != sent) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("timeout waiting for all sent instructions to retire");
            end
        end
        check_value("credits returned", 32'(sent), 32'(returned));
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- arm_core.f
arm_core_pkg.sv
ins_queue.sv
register_bank.sv
issue_stage.sv
operand_shifter.sv
exec_stage.sv
writeback_stage.sv
arm_core.sv
tb_arm_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the arm_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_arm_core \
    -f arm_core.f \
    -Mdir obj_dir -o tb_arm_core
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

./obj_dir/tb_arm_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "run_sim: FAIL"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $run_status"
    exit 1
fi

echo "run_sim: PASS"
exit 0
